//--- hw/iir_pkg.sv
package iir_pkg;

	// sample and coefficient widths
	localparam int SAMPLE_W = 8;
	localparam int COEF_W = 16;

	// internal sum widths
	// feedback keeps the 32-bit product less the shifted-out bits
	localparam int FB_W = 29;
	localparam int FF_W = 25;
	localparam int ACC_W = 27;
	localparam int FB_SHIFT = 3;

	// dout is result[26:19], stored history is result[26:11]
	localparam int OUT_MSB = 26;

	// sequencer timing
	localparam int SETTLE_CYCLES = 4;
	localparam int SETTLE_W = $clog2(SETTLE_CYCLES);
	localparam int RUN_LENGTH = 16;
	localparam int CNT_W = $clog2(RUN_LENGTH + 1);

	// coefficient load sequence on params
	localparam int NUM_COEFS = 5;
	localparam int POS_W = $clog2(NUM_COEFS);

	// a1 sits in the top field, it is the first word on params
	typedef struct packed {
		logic signed [COEF_W-1:0] a1;
		logic signed [COEF_W-1:0] a2;
		logic signed [COEF_W-1:0] b0;
		logic signed [COEF_W-1:0] b1;
		logic signed [COEF_W-1:0] b2;
	} iir_coefs_t;

	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		LOAD        = 4'd1,
		WAIT_START  = 4'd2,
		LATCH       = 4'd3,
		FEEDBACK    = 4'd4,
		FEEDFORWARD = 4'd5,
		SUM         = 4'd6,
		SETTLE      = 4'd7,
		EMIT        = 4'd8
	} iir_state_e;

	typedef enum logic [2:0] {
		OP_NONE        = 3'd0,
		OP_CLEAR       = 3'd1,
		OP_LATCH       = 3'd2,
		OP_FEEDBACK    = 3'd3,
		OP_FEEDFORWARD = 3'd4,
		OP_SUM         = 3'd5,
		OP_EMIT        = 3'd6
	} iir_op_e;

endpackage

//--- hw/iir_coef_loader.sv
`timescale 1ns/100ps

module iir_coef_loader import iir_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              iir_start,
	input  logic [COEF_W-1:0] params,
	output iir_coefs_t        coefs,
	output logic              coefs_valid
);

	// words still expected after the one on params now
	logic [POS_W-1:0] pos;
	logic shift_en;

	assign shift_en = iir_start || (pos != '0);

	// shift register of words, a1 ends up in the top field after five shifts
	always_ff @(posedge clk)
	begin
		if (shift_en)
			coefs <= {coefs[(NUM_COEFS-1)*COEF_W-1:0], params};
	end

	// position counter, a new iir_start restarts the load
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pos <= '0;
			coefs_valid <= 1'b0;
		end
		else if (iir_start)
		begin
			pos <= POS_W'(NUM_COEFS - 1);
			coefs_valid <= 1'b0;
		end
		else if (pos != '0)
		begin
			pos <= pos - 1'b1;
			// b2 is on params in this cycle
			if (pos == POS_W'(1))
				coefs_valid <= 1'b1;
		end
	end

	// a full set only shows up a fixed number of cycles after a load request
	a_valid_after_start: assert property (
		@(posedge clk) disable iff (reset)
		$rose(coefs_valid) |-> $past(iir_start, NUM_COEFS)
	) else
		$error("coefs_valid rose without iir_start %0d cycles earlier", NUM_COEFS);

endmodule

//--- hw/iir_biquad_ctrl.sv
`timescale 1ns/100ps

module iir_biquad_ctrl import iir_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    iir_start,
	input  logic    coefs_valid,
	input  logic    start,
	output iir_op_e op,
	output logic    ready,
	output logic    dout_valid,
	output logic    iir_done
);

	iir_state_e state;
	iir_state_e state_next;
	// the accept cycle counts as LATCH even though the register still holds WAIT_START
	iir_state_e step;

	logic [SETTLE_W-1:0] settle_cnt;
	logic [CNT_W-1:0] sample_cnt;
	logic accept;
	logic run_start;
	logic run_end;

	assign accept = (state == WAIT_START) && start;
	assign run_start = (state == IDLE) && iir_start;
	assign run_end = (sample_cnt == CNT_W'(RUN_LENGTH));
	assign step = accept ? LATCH : state;

	// next state and the opcode for this cycle
	always_comb
	begin
		state_next = step;
		op = OP_NONE;
		case (step)
			IDLE:
			begin
				if (iir_start)
				begin
					state_next = LOAD;
					op = OP_CLEAR;
				end
			end
			LOAD:
			begin
				if (coefs_valid)
					state_next = WAIT_START;
			end
			WAIT_START:
				state_next = WAIT_START;
			LATCH:
			begin
				state_next = FEEDBACK;
				op = OP_LATCH;
			end
			FEEDBACK:
			begin
				state_next = FEEDFORWARD;
				op = OP_FEEDBACK;
			end
			FEEDFORWARD:
			begin
				state_next = SUM;
				op = OP_FEEDFORWARD;
			end
			SUM:
			begin
				state_next = SETTLE;
				op = OP_SUM;
			end
			SETTLE:
			begin
				// dout is written in the last settle cycle so it is valid in EMIT
				if (settle_cnt == '0)
				begin
					state_next = EMIT;
					op = OP_EMIT;
				end
			end
			EMIT:
				state_next = run_end ? IDLE : WAIT_START;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	// settle wait and samples taken in this run
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			settle_cnt <= '0;
			sample_cnt <= '0;
		end
		else
		begin
			if (run_start)
				sample_cnt <= '0;
			else if (accept)
				sample_cnt <= sample_cnt + 1'b1;

			if (step == SUM)
				settle_cnt <= SETTLE_W'(SETTLE_CYCLES - 1);
			else if (state == SETTLE)
				settle_cnt <= settle_cnt - 1'b1;
		end
	end

	assign ready = (state == WAIT_START);
	assign dout_valid = (state == EMIT);
	assign iir_done = dout_valid && run_end;

	// inputs are not queued
	a_start_needs_ready: assert property (
		@(posedge clk) disable iff (reset)
		start |-> ready
	) else
		$error("start arrived while ready was low");

	a_valid_not_ready: assert property (
		@(posedge clk) disable iff (reset)
		dout_valid |-> !ready
	) else
		$error("dout_valid and ready high together");

endmodule

//--- hw/iir_biquad_datapath.sv
`timescale 1ns/100ps

module iir_biquad_datapath import iir_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  iir_op_e             op,
	input  iir_coefs_t          coefs,
	input  logic [SAMPLE_W-1:0] din,
	output logic [SAMPLE_W-1:0] dout
);

	// input history
	logic signed [SAMPLE_W-1:0] u0;
	logic signed [SAMPLE_W-1:0] u1;
	logic signed [SAMPLE_W-1:0] u2;
	// output history, upper result bits
	logic signed [COEF_W-1:0] y1;
	logic signed [COEF_W-1:0] y2;

	logic signed [FB_W-1:0] fb;
	logic signed [FF_W-1:0] ff;
	logic signed [ACC_W-1:0] result;

	logic signed [2*COEF_W-1:0] prod_a1;
	logic signed [2*COEF_W-1:0] prod_a2;
	logic signed [SAMPLE_W+COEF_W-1:0] prod_b0;
	logic signed [SAMPLE_W+COEF_W-1:0] prod_b1;
	logic signed [SAMPLE_W+COEF_W-1:0] prod_b2;
	logic signed [FB_W-1:0] fb_next;
	logic signed [FF_W-1:0] ff_next;
	logic signed [ACC_W-1:0] acc_next;

	assign prod_a1 = y1 * coefs.a1;
	assign prod_a2 = y2 * coefs.a2;
	assign prod_b0 = u0 * coefs.b0;
	assign prod_b1 = u1 * coefs.b1;
	assign prod_b2 = u2 * coefs.b2;

	// each feedback product drops its low FB_SHIFT bits before the add
	assign fb_next = $signed(prod_a1[2*COEF_W-1:FB_SHIFT])
		+ $signed(prod_a2[2*COEF_W-1:FB_SHIFT]);
	assign ff_next = prod_b0 + prod_b1 + prod_b2;
	// ff is sign extended, the sum wraps at ACC_W bits
	assign acc_next = $signed(fb[ACC_W-1:0]) + ff;

	always_ff @(posedge clk)
	begin
		case (op)
			OP_CLEAR:
			begin
				u0 <= '0;
				u1 <= '0;
				u2 <= '0;
				y1 <= '0;
				y2 <= '0;
			end
			OP_LATCH:
				u0 <= din;
			OP_FEEDBACK:
				fb <= fb_next;
			OP_FEEDFORWARD:
				ff <= ff_next;
			OP_SUM:
				result <= acc_next;
			OP_EMIT:
			begin
				u1 <= u0;
				u2 <= u1;
				y1 <= result[OUT_MSB -: COEF_W];
				y2 <= y1;
			end
			default:
				;
		endcase
	end

	// dout holds its value across runs, OP_CLEAR leaves it alone
	always_ff @(posedge clk)
	begin
		if (reset)
			dout <= '0;
		else if (op == OP_EMIT)
			dout <= result[OUT_MSB -: SAMPLE_W];
	end

	// the sequencer only ever issues the seven defined opcodes
	a_op_defined: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(op) && (op inside {OP_NONE, OP_CLEAR, OP_LATCH, OP_FEEDBACK,
			OP_FEEDFORWARD, OP_SUM, OP_EMIT})
	) else
		$error("undefined opcode %0d", op);

endmodule

//--- hw/iir_filter_top.sv
`timescale 1ns/100ps

module iir_filter_top import iir_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                iir_start,
	input  logic [COEF_W-1:0]   params,
	input  logic                start,
	input  logic [SAMPLE_W-1:0] din,
	output logic [SAMPLE_W-1:0] dout,
	output logic                dout_valid,
	output logic                ready,
	output logic                iir_done
);

	iir_coefs_t coefs;
	logic coefs_valid;
	iir_op_e op;

	iir_coef_loader u_loader (
		.clk         (clk),
		.reset       (reset),
		.iir_start   (iir_start),
		.params      (params),
		.coefs       (coefs),
		.coefs_valid (coefs_valid)
	);

	// sequencer drives one opcode per cycle into the datapath
	iir_biquad_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.iir_start   (iir_start),
		.coefs_valid (coefs_valid),
		.start       (start),
		.op          (op),
		.ready       (ready),
		.dout_valid  (dout_valid),
		.iir_done    (iir_done)
	);

	iir_biquad_datapath u_datapath (
		.clk   (clk),
		.reset (reset),
		.op    (op),
		.coefs (coefs),
		.din   (din),
		.dout  (dout)
	);

endmodule

//--- tests/iir_ref_model.svh
`ifndef IIR_REF_MODEL_SVH
`define IIR_REF_MODEL_SVH

// model history, same roles as the datapath registers
longint m_u0;
longint m_u1;
longint m_u2;
longint m_y1;
longint m_y2;

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(logic [15:0] s);
	logic lsb;
	lsb = s[0];
	s = s >> 1;
	if (lsb)
		s = s ^ 16'hB400;
	return s;
endfunction

// keep the low w bits of v as a signed number
function automatic longint wrap_signed(longint v, int w);
	longint m;
	longint span;
	span = longint'(1) << w;
	m = v & (span - 1);
	if (m >= (span >> 1))
		m = m - span;
	return m;
endfunction

function automatic void model_clear();
	m_u0 = 0;
	m_u1 = 0;
	m_u2 = 0;
	m_y1 = 0;
	m_y2 = 0;
endfunction

// one sample through the recurrence, returns the 8-bit output
function automatic logic [7:0] model_step(logic signed [7:0] din, iir_coefs_t c);
	longint fb;
	longint ff;
	longint res;
	m_u0 = longint'(din);
	fb = ((m_y1 * longint'(c.a1)) >>> 3) + ((m_y2 * longint'(c.a2)) >>> 3);
	fb = wrap_signed(fb, 29);
	ff = m_u0 * longint'(c.b0) + m_u1 * longint'(c.b1) + m_u2 * longint'(c.b2);
	ff = wrap_signed(ff, 25);
	res = wrap_signed(fb + ff, 27);
	m_u2 = m_u1;
	m_u1 = m_u0;
	m_y2 = m_y1;
	m_y1 = wrap_signed(res >>> 11, 16);
	return 8'((res >>> 19) & 255);
endfunction

`endif

//--- tests/tb_iir_filter.sv
`timescale 1ns/100ps

module tb_iir_filter import iir_pkg::*; ();

	localparam int WAIT_LIMIT = 60;

	logic clk;
	logic reset;
	logic iir_start;
	logic [15:0] params;
	logic start;
	logic [7:0] din;
	logic [7:0] dout;
	logic dout_valid;
	logic ready;
	logic iir_done;

	int error_count;
	int valid_count;
	int done_count;
	logic [15:0] lfsr_state;
	logic [7:0] exp_q[$];
	iir_coefs_t cur_coefs;
	// expected dout for the current pulse and whether there was one
	logic [7:0] exp_dout;
	logic exp_avail;

	`include "iir_ref_model.svh"

	iir_filter_top u_dut (
		.clk        (clk),
		.reset      (reset),
		.iir_start  (iir_start),
		.params     (params),
		.start      (start),
		.din        (din),
		.dout       (dout),
		.dout_valid (dout_valid),
		.ready      (ready),
		.iir_done   (iir_done)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// timing checks
	a_latency: assert property (@(posedge clk) disable iff (reset)
		(start && ready) |=> (!dout_valid [*7]) ##1 dout_valid)
	else
	begin
		error_count++;
		$display("dout_valid did not arrive 8 cycles after start at %0t", $time);
	end

	a_pulse: assert property (@(posedge clk) disable iff (reset)
		dout_valid |=> !dout_valid)
	else
	begin
		error_count++;
		$display("dout_valid stayed high for more than one cycle at %0t", $time);
	end

	a_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(dout_valid && ready))
	else
	begin
		error_count++;
		$display("dout_valid and ready were high together at %0t", $time);
	end

	a_ready_back: assert property (@(posedge clk) disable iff (reset)
		(dout_valid && !iir_done) |=> ready)
	else
	begin
		error_count++;
		$display("ready did not return after dout_valid at %0t", $time);
	end

	a_done_valid: assert property (@(posedge clk) disable iff (reset)
		iir_done |-> dout_valid)
	else
	begin
		error_count++;
		$display("iir_done came without dout_valid at %0t", $time);
	end

	a_done_idle: assert property (@(posedge clk) disable iff (reset)
		iir_done |=> !ready)
	else
	begin
		error_count++;
		$display("ready was high right after iir_done at %0t", $time);
	end

	// scoreboard head, taken off the queue mid-cycle where outputs are stable
	always @(negedge clk)
	begin
		if (!reset && dout_valid)
		begin
			valid_count++;
			if (iir_done)
				done_count++;
			exp_avail = (exp_q.size() != 0);
			if (exp_avail)
				exp_dout = exp_q.pop_front();
		end
	end

	a_dout_value: assert property (@(posedge clk) disable iff (reset)
		dout_valid |-> exp_avail && (dout == exp_dout))
	else
	begin
		error_count++;
		if (!exp_avail)
			$display("dout_valid at %0t with no output expected", $time);
		else
			$display("CHECK FAILED t=%0t dout expected %h got %h", $time, exp_dout, dout);
	end

	task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
		assert (expected === actual)
		else
		begin
			error_count++;
			$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// bounded to +-2047 so the recurrence does not wrap every sample
	function automatic logic [15:0] rand_coef();
		logic [15:0] b;
		b = rand_bits(12);
		return {{4{b[11]}}, b[11:0]};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic end_run();
		$display("checks done, errors: %0d", error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic give_up(string what);
		error_count++;
		$display("timeout at %0t: %s never came", $time, what);
		end_run();
	endtask

	// a1 goes with iir_start, then a2 b0 b1 b2
	task automatic load_coefs(iir_coefs_t c, bit fresh);
		logic [15:0] words[5];
		words = '{c.a1, c.a2, c.b0, c.b1, c.b2};
		for (int i = 0; i < 5; i++)
		begin
			iir_start = (i == 0);
			params = words[i];
			if (fresh)
				check_value("ready", 16'd0, {15'd0, ready});
			next_cycle();
		end
		iir_start = 1'b0;
		params = '0;
	endtask

	task automatic start_run(iir_coefs_t c);
		int k;
		cur_coefs = c;
		model_clear();
		load_coefs(c, 1'b1);
		k = 5;
		while (!ready)
		begin
			if (k > WAIT_LIMIT)
				give_up("ready after iir_start");
			next_cycle();
			k++;
		end
		check_value("ready_delay", 16'd6, 16'(k));
	endtask

	task automatic send_sample(logic [7:0] value);
		int k;
		k = 0;
		while (!ready)
		begin
			if (k > WAIT_LIMIT)
				give_up("ready for the next sample");
			next_cycle();
			k++;
		end
		start = 1'b1;
		din = value;
		exp_q.push_back(model_step(value, cur_coefs));
		next_cycle();
		start = 1'b0;
		din = 8'(rand_bits(8));
		k = 0;
		while (!dout_valid)
		begin
			if (k > WAIT_LIMIT)
				give_up("dout_valid");
			next_cycle();
			k++;
		end
	endtask

	task automatic finish_run(int valid_before, int done_before);
		// nothing more until a new iir_start
		for (int i = 0; i < 10; i++)
		begin
			next_cycle();
			check_value("ready", 16'd0, {15'd0, ready});
		end
		check_value("valid_count", 16'(RUN_LENGTH), 16'(valid_count - valid_before));
		check_value("done_count", 16'd1, 16'(done_count - done_before));
	endtask

	initial
	begin
		iir_coefs_t c;
		int v0;
		int d0;
		int k;
		logic [7:0] first;
		longint p;
		reset = 1'b1;
		iir_start = 1'b0;
		params = '0;
		start = 1'b0;
		din = '0;
		error_count = 0;
		valid_count = 0;
		done_count = 0;
		exp_dout = '0;
		exp_avail = 1'b0;
		lfsr_state = 16'd1954;

		repeat (5) @(posedge clk);
		#1;
		check_value("ready", 16'd0, {15'd0, ready});
		check_value("dout_valid", 16'd0, {15'd0, dout_valid});
		check_value("iir_done", 16'd0, {15'd0, iir_done});
		check_value("dout", 16'd0, {8'd0, dout});
		reset = 1'b0;
		next_cycle();

		// run 1, impulse response
		c.a1 = rand_coef();
		c.a2 = rand_coef();
		c.b0 = rand_coef();
		c.b1 = rand_coef();
		c.b2 = rand_coef();
		v0 = valid_count;
		d0 = done_count;
		start_run(c);
		send_sample(8'd64);
		for (int i = 1; i < RUN_LENGTH; i++)
			send_sample(8'd0);
		finish_run(v0, d0);

		// run 2, new coefficients and random samples
		c.a1 = rand_coef();
		c.a2 = rand_coef();
		c.b0 = rand_coef();
		c.b1 = rand_coef();
		c.b2 = rand_coef();
		v0 = valid_count;
		d0 = done_count;
		start_run(c);
		first = 8'(rand_bits(8));
		send_sample(first);
		// history was cleared, so only din*b0 reaches the output
		p = longint'($signed(first)) * longint'(c.b0);
		check_value("dout_first", {8'd0, 8'((p >>> 19) & 255)}, {8'd0, dout});
		for (int i = 1; i < RUN_LENGTH; i++)
		begin
			// iir_start mid-run with the same words must not disturb the run
			if (i == 6)
			begin
				k = 0;
				while (!ready)
				begin
					if (k > WAIT_LIMIT)
						give_up("ready before the mid-run iir_start");
					next_cycle();
					k++;
				end
				load_coefs(c, 1'b0);
			end
			send_sample(8'(rand_bits(8)));
		end
		finish_run(v0, d0);

		if (exp_q.size() != 0)
		begin
			error_count++;
			$display("%0d expected outputs never appeared", exp_q.size());
		end
		end_run();
	end

endmodule

//--- filelist.f
+incdir+tests
hw/iir_pkg.sv
hw/iir_coef_loader.sv
hw/iir_biquad_ctrl.sv
hw/iir_biquad_datapath.sv
hw/iir_filter_top.sv
tests/tb_iir_filter.sv

//--- Bender.yml
package:
  name: iir_filter

sources:
  - files:
      - hw/iir_pkg.sv
      - hw/iir_coef_loader.sv
      - hw/iir_biquad_ctrl.sv
      - hw/iir_biquad_datapath.sv
      - hw/iir_filter_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_iir_filter.sv
